// ==== design/cache_pkg.sv ====
`default_nettype none

package cache_pkg;

    typedef logic [19:0]  tag_t;
    typedef logic [7:0]   index_t;
    typedef logic [3:0]   offset_t;
    typedef logic [1:0]   bank_sel_t;   // offset[3:2]
    typedef logic [31:0]  word_t;
    typedef logic [3:0]   strb_t;
    typedef logic [127:0] line_t;       // word 0 in the low bits
    typedef logic [31:0]  addr_t;
    typedef logic [15:0]  bank_strb_t;  // four byte lanes per bank

    localparam logic OP_READ  = 1'b0;
    localparam logic OP_WRITE = 1'b1;

    localparam int NUM_SETS  = 256;
    localparam int NUM_BANKS = 4;

    localparam logic [2:0] LFSR_SEED = 3'b111;

    typedef struct packed {
        logic    op;
        tag_t    tag;
        index_t  index;
        offset_t offset;
        strb_t   wstrb;
        word_t   wdata;
    } cpu_req_t;

    typedef struct packed {
        logic  valid;
        logic  last;    // fourth beat of the line
        word_t data;
    } mem_ret_t;

    typedef struct packed {
        addr_t addr;
        line_t data;
    } wr_line_t;

    // one store hit waiting for its bank write
    typedef struct packed {
        logic      way;
        bank_sel_t bank;
        index_t    index;
        strb_t     strb;
        word_t     data;
    } wbuf_entry_t;

    typedef enum logic [4:0] {
        IDLE    = 5'b00001,
        LOOKUP  = 5'b00010,
        MISS    = 5'b00100,
        REPLACE = 5'b01000,
        REFILL  = 5'b10000
    } cache_state_e;

    typedef enum logic [1:0] {
        WB_IDLE  = 2'b01,
        WB_WRITE = 2'b10
    } wbuf_state_e;

endpackage

`default_nettype wire

// ==== design/sram_1rw.sv ====
`timescale 1ns/1ps
`default_nettype none

module sram_1rw #(
    parameter int  WIDTH  = 32,
    localparam int LANES  = (WIDTH % 8 == 0) ? WIDTH / 8 : 1,
    localparam int LANE_W = WIDTH / LANES
) (
    input  wire                    clk,
    input  wire cache_pkg::index_t addr,
    input  wire                    en,
    input  wire [LANES-1:0]        we,
    input  wire [WIDTH-1:0]        wdata,
    output logic [WIDTH-1:0]       rdata
);
    import cache_pkg::*;

    logic [WIDTH-1:0] mem [NUM_SETS];

    // read-first and rdata holds between accesses
    always_ff @(posedge clk) begin
        if (en) begin
            for (int i = 0; i < LANES; i++) begin
                if (we[i]) begin
                    mem[addr][i*LANE_W +: LANE_W] <= wdata[i*LANE_W +: LANE_W];
                end
            end
            rdata <= mem[addr];
        end
    end

endmodule

`default_nettype wire

// ==== design/cache_way.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_way (
    input  wire                            clk,
    input  wire                            reset,
    input  wire                            tag_en,
    input  wire                            tag_we,
    input  wire cache_pkg::index_t         ram_index,
    input  wire cache_pkg::tag_t           cmp_tag,
    input  wire [cache_pkg::NUM_BANKS-1:0] bank_en,
    input  wire cache_pkg::bank_strb_t     bank_strb,
    input  wire cache_pkg::word_t          bank_wdata,
    input  wire cache_pkg::index_t         dirty_index,
    input  wire                            dirty_set,
    input  wire                            dirty_clr,
    output logic                           hit,
    output logic                           line_valid,
    output cache_pkg::tag_t                stored_tag,
    output cache_pkg::line_t               line,
    output logic                           dirty
);
    import cache_pkg::*;

    logic [20:0]         tagv;          // {tag, valid}
    wire word_t          bank_rdata [NUM_BANKS];
    logic [NUM_SETS-1:0] dirty_bits;

    // a tag write always marks the line valid
    sram_1rw #(.WIDTH(21)) tag_ram (
        .clk   (clk),
        .addr  (ram_index),
        .en    (tag_en),
        .we    (tag_we),
        .wdata ({cmp_tag, 1'b1}),
        .rdata (tagv)
    );

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        sram_1rw #(.WIDTH(32)) bank_ram (
            .clk   (clk),
            .addr  (ram_index),
            .en    (bank_en[b]),
            .we    (bank_strb[b*4 +: 4]),
            .wdata (bank_wdata),
            .rdata (bank_rdata[b])
        );
    end

    always_comb begin
        for (int b = 0; b < NUM_BANKS; b++) begin
            line[b*32 +: 32] = bank_rdata[b];
        end
    end

    assign stored_tag = tagv[20:1];
    assign line_valid = tagv[0];
    assign hit        = line_valid && (stored_tag == cmp_tag);  // one cycle after the access

    assign dirty = dirty_bits[dirty_index];

    always_ff @(posedge clk) begin
        if (reset) begin
            dirty_bits <= '0;
        end else if (dirty_set) begin
            dirty_bits[dirty_index] <= 1'b1;
        end else if (dirty_clr) begin
            dirty_bits[dirty_index] <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== design/write_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module write_buffer (
    input  wire                         clk,
    input  wire                         reset,
    input  wire                         load,
    input  wire cache_pkg::wbuf_entry_t entry_in,
    output logic                        busy,
    output cache_pkg::wbuf_entry_t      entry
);
    import cache_pkg::*;

    wbuf_state_e state;

    // a load while writing keeps the buffer in WB_WRITE
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= WB_IDLE;
        end else begin
            state <= load ? WB_WRITE : WB_IDLE;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            entry <= entry_in;
        end
    end

    assign busy = (state == WB_WRITE);  // bank write happens in this cycle

endmodule

`default_nettype wire

// ==== design/cache_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl (
    input  wire                             clk,
    input  wire                             reset,
    // cpu side
    input  wire                             valid,
    input  wire cache_pkg::cpu_req_t        req,
    output logic                            addr_ok,
    output logic                            data_ok,
    output cache_pkg::word_t                rdata,
    // bus side
    output logic                            rd_req,
    output cache_pkg::addr_t                rd_addr,
    input  wire                             rd_rdy,
    input  wire cache_pkg::mem_ret_t        ret,
    output logic                            wr_req,
    output cache_pkg::wr_line_t             wr_line,
    input  wire                             wr_rdy,
    // way status
    input  wire                             way0_hit,
    input  wire                             way0_valid,
    input  wire cache_pkg::tag_t            way0_tag,
    input  wire cache_pkg::line_t           way0_line,
    input  wire                             way0_dirty,
    input  wire                             way1_hit,
    input  wire                             way1_valid,
    input  wire cache_pkg::tag_t            way1_tag,
    input  wire cache_pkg::line_t           way1_line,
    input  wire                             way1_dirty,
    // ram controls shared by both ways
    output cache_pkg::index_t               ram_index,
    output cache_pkg::tag_t                 cmp_tag,
    output cache_pkg::word_t                bank_wdata,
    output cache_pkg::index_t               dirty_index,
    // per-way ram controls
    output logic                            way0_tag_en,
    output logic                            way0_tag_we,
    output logic [cache_pkg::NUM_BANKS-1:0] way0_bank_en,
    output cache_pkg::bank_strb_t           way0_bank_strb,
    output logic                            way0_dirty_set,
    output logic                            way0_dirty_clr,
    output logic                            way1_tag_en,
    output logic                            way1_tag_we,
    output logic [cache_pkg::NUM_BANKS-1:0] way1_bank_en,
    output cache_pkg::bank_strb_t           way1_bank_strb,
    output logic                            way1_dirty_set,
    output logic                            way1_dirty_clr,
    // write buffer
    output logic                            wbuf_load,
    output cache_pkg::wbuf_entry_t          wbuf_entry_in,
    input  wire                             wbuf_busy,
    input  wire cache_pkg::wbuf_entry_t     wbuf_entry
);
    import cache_pkg::*;

    cache_state_e         state;
    cache_state_e         next_state;
    cpu_req_t             rq;           // request buffer
    bank_sel_t            refill_cnt;
    logic [2:0]           lfsr;
    logic                 victim_ok;    // victim set has been read back in MISS

    logic                 cache_hit, accept, victim, victim_dirty;
    logic                 victim_path, refill_beat, refill_done;
    logic                 conflict_wbuf, conflict_store;
    bank_sel_t            req_bank, rq_bank;
    logic [1:0]           victim_sel, wbuf_sel;
    logic [NUM_BANKS-1:0] req_bank_oh, wbuf_bank_oh, refill_oh;
    word_t                refill_word;
    logic [1:0]           tag_en_w, tag_we_w, dirty_set_w, dirty_clr_w;
    logic [NUM_BANKS-1:0] bank_en_w [2];
    bank_strb_t           bank_strb_w [2];

    assign req_bank    = req.offset[3:2];
    assign rq_bank     = rq.offset[3:2];
    assign cache_hit   = way0_hit || way1_hit;
    assign victim      = lfsr[0];
    assign victim_path = (state == MISS) || (state == REPLACE) || (state == REFILL);
    assign refill_beat = (state == REFILL) && ret.valid;
    assign refill_done = refill_beat && ret.last;

    // the written way has one address for tags and banks, so a new access
    // must sit in the buffered set and a read must avoid the buffered bank
    assign conflict_wbuf = valid && wbuf_busy &&
                           ((req.op == OP_READ && req_bank == wbuf_entry.bank) ||
                            req.index != wbuf_entry.index);
    // load of the word that the store in LOOKUP has not written yet
    assign conflict_store = valid && (state == LOOKUP) && (rq.op == OP_WRITE) &&
                            (req.op == OP_READ) &&
                            ({req.tag, req.index, req_bank} == {rq.tag, rq.index, rq_bank});

    assign addr_ok = ((state == IDLE) || (state == LOOKUP && cache_hit)) &&
                     !conflict_wbuf && !conflict_store;
    assign accept  = valid && addr_ok;

    always_comb begin
        case (state)
            IDLE:    next_state = accept ? LOOKUP : IDLE;
            LOOKUP:  next_state = !cache_hit ? MISS : (accept ? LOOKUP : IDLE);
            MISS:    next_state = (victim_ok && (!victim_dirty || wr_rdy)) ? REPLACE : MISS;
            REPLACE: next_state = rd_rdy ? REFILL : REPLACE;
            REFILL:  next_state = refill_done ? IDLE : REFILL;
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= IDLE;
            refill_cnt <= '0;
            lfsr       <= LFSR_SEED;
            victim_ok  <= 1'b0;
        end else begin
            state     <= next_state;
            victim_ok <= (state == MISS);   // first MISS cycle re-reads the set
            if (refill_beat) begin
                refill_cnt <= refill_cnt + 2'd1;  // wraps after four beats
            end
            if (refill_done) begin
                lfsr <= {lfsr[0], lfsr[2] ^ lfsr[0], lfsr[1]};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            rq <= req;
        end
    end

    assign victim_dirty = victim ? (way1_dirty && way1_valid) : (way0_dirty && way0_valid);

    // store miss bytes merged into the returning word
    always_comb begin
        refill_word = ret.data;
        if (rq.op == OP_WRITE && refill_cnt == rq_bank) begin
            for (int i = 0; i < 4; i++) begin
                if (rq.wstrb[i]) begin
                    refill_word[i*8 +: 8] = rq.wdata[i*8 +: 8];
                end
            end
        end
    end

    assign ram_index   = victim_path ? rq.index : (wbuf_busy ? wbuf_entry.index : req.index);
    assign cmp_tag     = rq.tag;
    assign bank_wdata  = (state == REFILL) ? refill_word : wbuf_entry.data;
    assign dirty_index = wbuf_busy ? wbuf_entry.index : rq.index;

    assign victim_sel   = {victim, !victim};
    assign wbuf_sel     = {2{wbuf_busy}} & {wbuf_entry.way, !wbuf_entry.way};
    assign req_bank_oh  = 4'b0001 << req_bank;
    assign wbuf_bank_oh = 4'b0001 << wbuf_entry.bank;
    assign refill_oh    = 4'b0001 << refill_cnt;

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            tag_en_w[w]    = accept || (victim_path && victim_sel[w]);
            tag_we_w[w]    = refill_done && victim_sel[w];
            dirty_set_w[w] = wbuf_sel[w] || (tag_we_w[w] && rq.op == OP_WRITE);
            dirty_clr_w[w] = tag_we_w[w] && rq.op == OP_READ;
            bank_en_w[w]   = ({NUM_BANKS{accept}} & req_bank_oh) |
                             ({NUM_BANKS{wbuf_sel[w]}} & wbuf_bank_oh) |
                             {NUM_BANKS{victim_path && victim_sel[w]}};
            for (int b = 0; b < NUM_BANKS; b++) begin
                bank_strb_w[w][b*4 +: 4] =
                    ({4{wbuf_sel[w] && wbuf_bank_oh[b]}} & wbuf_entry.strb) |
                    {4{refill_beat && victim_sel[w] && refill_oh[b]}};
            end
        end
    end

    assign way0_tag_en    = tag_en_w[0];
    assign way0_tag_we    = tag_we_w[0];
    assign way0_bank_en   = bank_en_w[0];
    assign way0_bank_strb = bank_strb_w[0];
    assign way0_dirty_set = dirty_set_w[0];
    assign way0_dirty_clr = dirty_clr_w[0];
    assign way1_tag_en    = tag_en_w[1];
    assign way1_tag_we    = tag_we_w[1];
    assign way1_bank_en   = bank_en_w[1];
    assign way1_bank_strb = bank_strb_w[1];
    assign way1_dirty_set = dirty_set_w[1];
    assign way1_dirty_clr = dirty_clr_w[1];

    // write miss is acknowledged in LOOKUP like a hit
    assign data_ok = (state == LOOKUP && (cache_hit || rq.op == OP_WRITE)) ||
                     (refill_beat && refill_cnt == rq_bank && rq.op == OP_READ);
    assign rdata   = (state == REFILL) ? ret.data :
                     (way1_hit ? way1_line[{rq_bank, 5'd0} +: 32] :
                                 way0_line[{rq_bank, 5'd0} +: 32]);

    assign rd_req  = (state == REPLACE);
    assign rd_addr = {rq.tag, rq.index, 4'b0000};
    assign wr_req  = (state == MISS) && victim_ok && victim_dirty;
    assign wr_line = victim ? {way1_tag, rq.index, 4'b0000, way1_line} :
                              {way0_tag, rq.index, 4'b0000, way0_line};

    assign wbuf_load     = (state == LOOKUP) && (rq.op == OP_WRITE) && cache_hit;
    assign wbuf_entry_in = {way1_hit, rq_bank, rq.index, rq.wstrb, rq.wdata};

endmodule

`default_nettype wire

// ==== design/cache_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_top (
    input  wire                      clk,
    input  wire                      reset,
    input  wire                      valid,
    input  wire cache_pkg::cpu_req_t req,
    output logic                     addr_ok,
    output logic                     data_ok,
    output cache_pkg::word_t         rdata,
    output logic                     rd_req,
    output cache_pkg::addr_t         rd_addr,
    input  wire                      rd_rdy,
    input  wire cache_pkg::mem_ret_t ret,
    output logic                     wr_req,
    output cache_pkg::wr_line_t      wr_line,
    input  wire                      wr_rdy
);
    import cache_pkg::*;

    logic                 way0_hit, way0_valid, way0_dirty;
    tag_t                 way0_tag;
    line_t                way0_line;
    logic                 way1_hit, way1_valid, way1_dirty;
    tag_t                 way1_tag;
    line_t                way1_line;

    index_t               ram_index, dirty_index;
    tag_t                 cmp_tag;
    word_t                bank_wdata;

    logic                 way0_tag_en, way0_tag_we, way0_dirty_set, way0_dirty_clr;
    logic [NUM_BANKS-1:0] way0_bank_en;
    bank_strb_t           way0_bank_strb;
    logic                 way1_tag_en, way1_tag_we, way1_dirty_set, way1_dirty_clr;
    logic [NUM_BANKS-1:0] way1_bank_en;
    bank_strb_t           way1_bank_strb;

    logic                 wbuf_load, wbuf_busy;
    wbuf_entry_t          wbuf_entry_in, wbuf_entry;

    // every controller port has a signal of the same name here
    cache_ctrl ctrl_i (.*);

    cache_way way0_i (
        .clk         (clk),
        .reset       (reset),
        .tag_en      (way0_tag_en),
        .tag_we      (way0_tag_we),
        .ram_index   (ram_index),
        .cmp_tag     (cmp_tag),
        .bank_en     (way0_bank_en),
        .bank_strb   (way0_bank_strb),
        .bank_wdata  (bank_wdata),
        .dirty_index (dirty_index),
        .dirty_set   (way0_dirty_set),
        .dirty_clr   (way0_dirty_clr),
        .hit         (way0_hit),
        .line_valid  (way0_valid),
        .stored_tag  (way0_tag),
        .line        (way0_line),
        .dirty       (way0_dirty)
    );

    cache_way way1_i (
        .clk         (clk),
        .reset       (reset),
        .tag_en      (way1_tag_en),
        .tag_we      (way1_tag_we),
        .ram_index   (ram_index),
        .cmp_tag     (cmp_tag),
        .bank_en     (way1_bank_en),
        .bank_strb   (way1_bank_strb),
        .bank_wdata  (bank_wdata),
        .dirty_index (dirty_index),
        .dirty_set   (way1_dirty_set),
        .dirty_clr   (way1_dirty_clr),
        .hit         (way1_hit),
        .line_valid  (way1_valid),
        .stored_tag  (way1_tag),
        .line        (way1_line),
        .dirty       (way1_dirty)
    );

    write_buffer wbuf_i (
        .clk      (clk),
        .reset    (reset),
        .load     (wbuf_load),
        .entry_in (wbuf_entry_in),
        .busy     (wbuf_busy),
        .entry    (wbuf_entry)
    );

endmodule

`default_nettype wire

// ==== tb/bus_mem_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus_mem_model #(
    parameter logic [31:0] SEED = 32'h1
) (
    input  wire                       clk,
    input  wire                       reset,
    input  wire [3:0]                 delay_max,   // 0 means no stalls
    input  wire                       rd_req,
    input  wire cache_pkg::addr_t     rd_addr,
    output logic                      rd_rdy,
    output cache_pkg::mem_ret_t       ret,
    input  wire                       wr_req,
    input  wire cache_pkg::wr_line_t  wr_line,
    output logic                      wr_rdy
);
    import cache_pkg::*;

    word_t       mem [addr_t];   // only written words are stored
    line_t       beat_line;
    int          beats_left;
    int          gap;
    logic [31:0] rng;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // pattern of untouched memory over every address bit
    function automatic word_t fill_word(input addr_t a);
        return a ^ {a[15:0], a[31:16]} ^ 32'h5a5a_3c3c;
    endfunction

    function automatic word_t mem_word(input addr_t a);
        return mem.exists(a) ? mem[a] : fill_word(a);
    endfunction

    always @(posedge clk) begin
        if (reset) begin
            rd_rdy     <= 1'b0;
            wr_rdy     <= 1'b0;
            ret        <= '0;
            beats_left = 0;
            gap        = 0;
            rng        = SEED;
        end else begin
            rng = xorshift32(rng);
            rd_rdy <= (int'(rng[7:0]) % (int'(delay_max) + 1)) == 0;
            wr_rdy <= (int'(rng[15:8]) % (int'(delay_max) + 1)) == 0;
            ret    <= '0;
            if (wr_req && wr_rdy) begin
                for (int i = 0; i < NUM_BANKS; i++) begin
                    mem[wr_line.addr + addr_t'(4 * i)] = wr_line.data[i*32 +: 32];
                end
            end
            if (rd_req && rd_rdy) begin
                for (int i = 0; i < NUM_BANKS; i++) begin
                    beat_line[i*32 +: 32] = mem_word(rd_addr + addr_t'(4 * i));
                end
                beats_left = 4;
                gap = int'(rng[23:16]) % (int'(delay_max) + 1);
            end else if (beats_left > 0) begin
                if (gap > 0) begin
                    gap--;
                end else begin
                    ret <= '{valid: 1'b1, last: (beats_left == 1),
                             data: beat_line[(4 - beats_left)*32 +: 32]};
                    beats_left--;
                    gap = int'(rng[31:24]) % (int'(delay_max) + 1);  // gap to next beat
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== tb/cache_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_tb;
    import cache_pkg::*;

    localparam logic [31:0] SEED         = 32'h90fed59d;
    localparam int          NUM_ACCESSES = 36;  // two rounds of 18 accesses
    localparam int          MAX_DELAY    = 7;
    localparam int          CYCLE_LIMIT  = 40 * (NUM_ACCESSES + MAX_DELAY);
    localparam logic [6:0]  VICTIM_SEQ   = 7'b1010011;  // bit i is the way of miss i

    logic       clk, reset, valid;
    cpu_req_t   req;
    logic       addr_ok, data_ok, rd_req, rd_rdy, wr_req, wr_rdy;
    word_t      rdata;
    addr_t      rd_addr;
    mem_ret_t   ret;
    wr_line_t   wr_line;
    logic [3:0] delay_max;

    // reference model of what the CPU should see
    word_t       ref_mem [addr_t];
    tag_t        mtag   [2][NUM_SETS];
    logic        mval   [2][NUM_SETS];
    logic        mdirty [2][NUM_SETS];
    int          miss_count, cycle_count;
    addr_t       exp_rd_q[$];
    addr_t       exp_wb_q[$];
    line_t       exp_wb_line_q[$];
    logic        rd_pend, wr_pend;
    logic [31:0] rng;

    cache_top cache_top_i (.*);
    bus_mem_model #(.SEED(SEED)) mem_i (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic word_t rand_word();
        rng = xorshift32(rng);
        return rng;
    endfunction

    function automatic word_t fill_word(input addr_t a);
        return a ^ {a[15:0], a[31:16]} ^ 32'h5a5a_3c3c;
    endfunction

    function automatic word_t expected_word(input addr_t a);
        return ref_mem.exists(a) ? ref_mem[a] : fill_word(a);
    endfunction

    function automatic line_t expected_line(input addr_t la);
        line_t l;
        for (int i = 0; i < NUM_BANKS; i++) begin
            l[i*32 +: 32] = expected_word(la + addr_t'(4 * i));
        end
        return l;
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) fail_run($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp) fail_run($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_line(input string name, input line_t got, input line_t exp);
        if (got !== exp) fail_run($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
    endtask

    // update the tag model and queue the bus traffic this access must cause
    task automatic predict(input logic op, input addr_t a, input strb_t wstrb,
                           input word_t wdata, output logic hit);
        index_t s;
        tag_t   t;
        int     v;
        addr_t  wa;
        word_t  w;
        s   = a[11:4];
        t   = a[31:12];
        hit = 1'b0;
        for (int k = 0; k < 2; k++) begin
            if (mval[k][s] && mtag[k][s] == t) begin
                hit = 1'b1;
                if (op == OP_WRITE) mdirty[k][s] = 1'b1;
            end
        end
        if (!hit) begin
            v = int'(VICTIM_SEQ[miss_count % 7]);
            miss_count++;
            if (mval[v][s] && mdirty[v][s]) begin
                exp_wb_q.push_back({mtag[v][s], s, 4'h0});
                exp_wb_line_q.push_back(expected_line({mtag[v][s], s, 4'h0}));
            end
            exp_rd_q.push_back({t, s, 4'h0});
            mval[v][s]   = 1'b1;
            mtag[v][s]   = t;
            mdirty[v][s] = (op == OP_WRITE);
        end
        if (op == OP_WRITE) begin
            wa = {a[31:2], 2'b00};
            w  = expected_word(wa);
            for (int i = 0; i < 4; i++) begin
                if (wstrb[i]) w[i*8 +: 8] = wdata[i*8 +: 8];
            end
            ref_mem[wa] = w;
        end
    endtask

    task automatic drive_req(input logic op, input addr_t a, input strb_t wstrb,
                             input word_t wdata);
        valid <= 1'b1;
        req   <= '{op: op, tag: a[31:12], index: a[11:4], offset: a[3:0],
                   wstrb: wstrb, wdata: wdata};
    endtask

    task automatic access(input logic op, input addr_t a, input strb_t wstrb,
                          input word_t wdata);
        logic  hit;
        word_t exp;
        int    lat;
        predict(op, a, wstrb, wdata, hit);
        exp = expected_word({a[31:2], 2'b00});
        drive_req(op, a, wstrb, wdata);
        do @(posedge clk); while (!addr_ok);
        valid <= 1'b0;
        lat = 0;
        do begin
            @(posedge clk);
            lat++;
        end while (!data_ok);
        if (op == OP_READ) check_word("rdata", rdata, exp);
        if ((hit || op == OP_WRITE) && lat != 1) begin
            fail_run("data_ok did not come one cycle after acceptance");
        end
    endtask

    // load issued right behind a store to the same word, both hits
    task automatic store_load_pair(input addr_t a, input strb_t wstrb, input word_t wdata);
        logic  hit;
        word_t exp;
        int    n_ok;
        predict(OP_WRITE, a, wstrb, wdata, hit);
        predict(OP_READ, a, 4'h0, '0, hit);
        exp = expected_word({a[31:2], 2'b00});
        drive_req(OP_WRITE, a, wstrb, wdata);
        do @(posedge clk); while (!addr_ok);
        drive_req(OP_READ, a, 4'h0, '0);
        n_ok = 0;
        while (n_ok < 2) begin
            @(posedge clk);
            if (valid && addr_ok) valid <= 1'b0;
            if (data_ok) begin
                n_ok++;
                if (n_ok == 2) check_word("rdata", rdata, exp);
            end
        end
    endtask

    task automatic wait_bus_idle();
        while (exp_rd_q.size() != 0 || exp_wb_q.size() != 0) @(posedge clk);
        repeat (2) @(posedge clk);
    endtask

    task automatic read_miss_test(input tag_t t);
        access(OP_READ, {t, 8'h10, 4'h4}, 4'h0, '0);
        wait_bus_idle();
    endtask

    task automatic read_hit_test(input tag_t t);
        for (int i = 0; i < NUM_BANKS; i++) begin
            access(OP_READ, {t, 8'h10, 2'(i), 2'b00}, 4'h0, '0);
        end
    endtask

    task automatic write_hit_test(input tag_t t);
        access(OP_WRITE, {t, 8'h10, 4'h8}, 4'b0101, rand_word());
        access(OP_READ, {t, 8'h10, 4'h8}, 4'h0, '0);   // stalls on the buffered bank
        access(OP_WRITE, {t, 8'h10, 4'hc}, 4'b1000, rand_word());
        access(OP_READ, {t, 8'h10, 4'hc}, 4'h0, '0);
        store_load_pair({t, 8'h10, 4'h0}, 4'b0011, rand_word());
    endtask

    task automatic write_miss_test(input tag_t t);
        access(OP_WRITE, {t, 8'h52, 4'h4}, 4'b0110, rand_word());
        access(OP_READ, {t, 8'h52, 4'h4}, 4'h0, '0);
        access(OP_READ, {t, 8'h52, 4'h0}, 4'h0, '0);
        wait_bus_idle();
    endtask

    task automatic eviction_test(input tag_t t);
        for (int k = 1; k <= 3; k++) begin
            access(OP_WRITE, {t + tag_t'(k), 8'h10, 2'(k), 2'b00}, 4'hf, rand_word());
        end
        access(OP_READ, {t, 8'h10, 4'h8}, 4'h0, '0);   // back from memory
        wait_bus_idle();
    endtask

    task automatic run_round(input tag_t t);
        read_miss_test(t);
        read_hit_test(t);
        write_hit_test(t);
        write_miss_test(t);
        eviction_test(t);
    endtask

    task automatic backpressure_test();
        delay_max <= 4'(MAX_DELAY);
        run_round(20'h00400);
    endtask

    // bus handshake monitor and timeout
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > CYCLE_LIMIT) fail_run("timeout, the cache stopped responding");
        if (reset) begin
            rd_pend <= 1'b0;
            wr_pend <= 1'b0;
        end else begin
            if ((rd_req || wr_req) && addr_ok) fail_run("addr_ok high during a bus request");
            if (rd_pend && !rd_req) fail_run("rd_req dropped before rd_rdy");
            if (wr_pend && !wr_req) fail_run("wr_req dropped before wr_rdy");
            if (rd_req && rd_rdy) begin
                if (exp_rd_q.size() == 0) fail_run("unexpected bus read");
                else check_addr("rd_addr", rd_addr, exp_rd_q.pop_front());
            end
            if (wr_req && wr_rdy) begin
                if (exp_wb_q.size() == 0) begin
                    fail_run("unexpected writeback");
                end else begin
                    check_addr("wr_line.addr", wr_line.addr, exp_wb_q.pop_front());
                    check_line("wr_line.data", wr_line.data, exp_wb_line_q.pop_front());
                end
            end
            rd_pend <= rd_req && !rd_rdy;
            wr_pend <= wr_req && !wr_rdy;
        end
    end

    initial begin
        reset       = 1'b1;
        valid       = 1'b0;
        req         = '0;
        delay_max   = 4'd0;
        rng         = SEED;
        miss_count  = 0;
        cycle_count = 0;
        for (int s = 0; s < NUM_SETS; s++) begin
            for (int k = 0; k < 2; k++) begin
                mval[k][s]   = 1'b0;
                mdirty[k][s] = 1'b0;
            end
        end
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        run_round(20'h00012);
        backpressure_test();
        wait_bus_idle();
        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
design/cache_pkg.sv
design/sram_1rw.sv
design/cache_way.sv
design/write_buffer.sv
design/cache_ctrl.sv
design/cache_top.sv
tb/bus_mem_model.sv
tb/cache_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
FILELIST   := build.f
TOP        := cache_tb
LINT_TOP   := cache_top
LINT_FLAGS := --lint-only
SIM_FLAGS  := --binary --timing -j 0
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(LINT_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Testbench passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
